// ==== verilog/bus_pkg.sv ====
package bus_pkg;

  // shared data bus
  localparam int data_width = 32;

  // the attribute bus carries one bit more than attr_width
  localparam int attr_width = 4;
  localparam int attr_bus_width = attr_width + 1;

  localparam int invalid_bit = 0; // attribute bit that marks a value as invalid

  // multiplier operand width
  localparam int half_width = 16;

  // bits from the top down to fit_lsb must all match for a value to fit a signed operand
  localparam int fit_lsb = half_width - 1;

  localparam logic [data_width-1:0] data_idle = '0; // level of a data output that is not enabled
  localparam logic [attr_bus_width-1:0] attr_idle = '0;

  // attribute word with only the invalid bit set
  localparam logic [attr_bus_width-1:0] attr_invalid =
    {{attr_width{1'b0}}, 1'b1} << invalid_bit;

endpackage

// ==== verilog/ctrl_pkg.sv ====
package ctrl_pkg;

  typedef enum logic [1:0] {
    op_nop  = 2'd0, // with the halt flag set this stops the program
    op_imm  = 2'd1,
    op_send = 2'd2,
    op_out  = 2'd3
  } opcode_t;

  typedef enum logic {
    unit_mult  = 1'b0,
    unit_accum = 1'b1
  } unit_id_t;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_run  = 2'd1,
    st_done = 2'd2
  } seq_state_t;

  localparam int prog_depth = 32;
  localparam int prog_addr_width = 5;
  localparam int prog_word_width = 40;

  // microcode word, immediate in the low bits and opcode on top
  localparam int imm_lsb = 0;
  localparam int imm_msb = imm_lsb + bus_pkg::data_width - 1;
  localparam int spare_bit = 32;
  localparam int imm_inv_bit = 33;
  localparam int sel_bit = 34;
  localparam int dst_bit = 35;
  localparam int src_bit = 36;
  localparam int halt_bit = 37;
  localparam int opcode_lsb = 38;
  localparam int opcode_msb = 39;

endpackage

// ==== verilog/pu_mult.sv ====
`timescale 1ns/1ns

module pu_mult (
  input  logic                                clk,
  input  logic                                rst,

  input  logic                                signal_wr,
  input  logic                                signal_sel,
  input  logic [bus_pkg::data_width-1:0]      data_in,
  input  logic [bus_pkg::attr_bus_width-1:0]  attr_in,

  input  logic                                signal_oe,
  output logic [bus_pkg::data_width-1:0]      data_out,
  output logic [bus_pkg::attr_bus_width-1:0]  attr_out
);

  logic [bus_pkg::data_width-1:0] arg [2];
  logic                           arg_invalid [2];

  logic signed [bus_pkg::data_width-1:0] product;
  logic                                  args_bad;
  logic                                  args_bad_q;
  logic                                  sel_q;
  logic                                  capture;

  logic [bus_pkg::data_width-1:0]     result_data;
  logic                               result_invalid;
  logic [bus_pkg::attr_bus_width-1:0] result_attr;

  // true when the upper bits are a plain sign extension of the operand
  function automatic logic fits_half(input logic [bus_pkg::data_width-1:0] v);
    logic [bus_pkg::data_width-1:bus_pkg::fit_lsb] upper;
    upper = v[bus_pkg::data_width-1:bus_pkg::fit_lsb];
    return (&upper) || !(|upper);
  endfunction

  always_ff @(posedge clk) begin
    if (signal_wr) begin
      arg[signal_sel] <= data_in;
      arg_invalid[signal_sel] <= attr_in[bus_pkg::invalid_bit];
    end
  end

  assign product = $signed(arg[0][bus_pkg::half_width-1:0])
                 * $signed(arg[1][bus_pkg::half_width-1:0]);

  assign args_bad = !fits_half(arg[0]) || !fits_half(arg[1])
                 || arg_invalid[0] || arg_invalid[1];

  always_ff @(posedge clk) begin
    args_bad_q <= args_bad; // lines up with the capture strobe
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sel_q <= 1'b0;
      capture <= 1'b0;
    end else begin
      sel_q <= signal_sel;
      capture <= !signal_sel && sel_q; // sel went back to 0 after the second argument
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_data <= '0;
      result_invalid <= 1'b0;
    end else if (capture) begin
      result_data <= product;
      result_invalid <= args_bad_q;
    end
  end

  always_comb begin
    result_attr = bus_pkg::attr_idle;
    result_attr[bus_pkg::invalid_bit] = result_invalid;
  end

  assign data_out = signal_oe ? result_data : bus_pkg::data_idle;
  assign attr_out = signal_oe ? result_attr : bus_pkg::attr_idle;

  // the sequencer never writes and reads this unit in the same word
  a_no_wr_with_oe: assert property (
    @(posedge clk) disable iff (rst) !(signal_wr && signal_oe)
  );

endmodule

// ==== verilog/pu_accum.sv ====
`timescale 1ns/1ns

module pu_accum (
  input  logic                                clk,
  input  logic                                rst,

  input  logic                                signal_wr,
  input  logic                                signal_sel,
  input  logic [bus_pkg::data_width-1:0]      data_in,
  input  logic [bus_pkg::attr_bus_width-1:0]  attr_in,

  input  logic                                signal_oe,
  output logic [bus_pkg::data_width-1:0]      data_out,
  output logic [bus_pkg::attr_bus_width-1:0]  attr_out
);

  localparam int msb = bus_pkg::data_width - 1;

  logic signed [bus_pkg::data_width-1:0] acc;
  logic                                  acc_invalid;
  logic signed [bus_pkg::data_width-1:0] sum;
  logic                                  sum_ovf;
  logic [bus_pkg::attr_bus_width-1:0]    acc_attr;
  logic [bus_pkg::data_width:0]          sum_wide;

  assign sum = acc + $signed(data_in);

  // operands of equal sign giving a sum of the other sign
  assign sum_ovf = (acc[msb] == data_in[msb]) && (sum[msb] != acc[msb]);

  // the sign-extended sum has two different top bits exactly when the result does not fit
  assign sum_wide = {acc[msb], acc} + {data_in[msb], data_in};

  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
      acc_invalid <= 1'b0;
    end else if (signal_wr) begin
      if (signal_sel) begin
        acc <= sum;
        acc_invalid <= acc_invalid || attr_in[bus_pkg::invalid_bit] || sum_ovf; // sticky
      end else begin
        acc <= $signed(data_in);
        acc_invalid <= attr_in[bus_pkg::invalid_bit]; // a load starts clean
      end
    end
  end

  always_comb begin
    acc_attr = bus_pkg::attr_idle;
    acc_attr[bus_pkg::invalid_bit] = acc_invalid;
  end

  assign data_out = signal_oe ? acc : bus_pkg::data_idle;
  assign attr_out = signal_oe ? acc_attr : bus_pkg::attr_idle;

  a_ovf_sets_invalid: assert property (
    @(posedge clk) disable iff (rst)
    signal_wr && signal_sel && (sum_wide[msb+1] != sum_wide[msb]) |=> acc_invalid
  );

endmodule

// ==== verilog/microcode_seq.sv ====
`timescale 1ns/1ns

module microcode_seq (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  start,

  input  logic                                  prog_wr,
  input  logic [ctrl_pkg::prog_addr_width-1:0]  prog_addr,
  input  logic [ctrl_pkg::prog_word_width-1:0]  prog_data,

  input  logic [bus_pkg::data_width-1:0]        bus_in_data,
  input  logic [bus_pkg::attr_bus_width-1:0]    bus_in_attr,

  output logic                                  mult_wr,
  output logic                                  mult_sel,
  output logic                                  mult_oe,
  output logic                                  accum_wr,
  output logic                                  accum_sel,
  output logic                                  accum_oe,

  output logic [bus_pkg::data_width-1:0]        bus_data,
  output logic [bus_pkg::attr_bus_width-1:0]    bus_attr,

  output logic [bus_pkg::data_width-1:0]        result_data,
  output logic [bus_pkg::attr_bus_width-1:0]    result_attr,
  output logic                                  result_valid,
  output logic                                  busy,
  output logic                                  done
);

  logic [ctrl_pkg::prog_word_width-1:0] prog_mem [ctrl_pkg::prog_depth];

  ctrl_pkg::seq_state_t                 state;
  ctrl_pkg::seq_state_t                 state_next;
  logic [ctrl_pkg::prog_addr_width-1:0] pc;

  logic [ctrl_pkg::prog_word_width-1:0] word;
  ctrl_pkg::opcode_t                    op;
  ctrl_pkg::unit_id_t                   src;
  ctrl_pkg::unit_id_t                   dst;
  logic                                 run;
  logic                                 halt_word;
  logic                                 unit_wr;
  logic                                 unit_oe;
  logic                                 imm_drive;
  logic                                 out_word;

  always_ff @(posedge clk) begin
    if (prog_wr && state == ctrl_pkg::st_idle) begin
      prog_mem[prog_addr] <= prog_data;
    end
  end

  assign word = prog_mem[pc]; // small enough for an asynchronous read
  assign run = state == ctrl_pkg::st_run;
  assign op = ctrl_pkg::opcode_t'(word[ctrl_pkg::opcode_msb:ctrl_pkg::opcode_lsb]);
  assign src = ctrl_pkg::unit_id_t'(word[ctrl_pkg::src_bit]);
  assign dst = ctrl_pkg::unit_id_t'(word[ctrl_pkg::dst_bit]);

  assign halt_word = run && op == ctrl_pkg::op_nop && word[ctrl_pkg::halt_bit];
  assign unit_wr = run && (op == ctrl_pkg::op_imm || op == ctrl_pkg::op_send);
  assign unit_oe = run && (op == ctrl_pkg::op_send || op == ctrl_pkg::op_out);
  assign imm_drive = run && op == ctrl_pkg::op_imm;
  assign out_word = run && op == ctrl_pkg::op_out;

  assign mult_wr = unit_wr && dst == ctrl_pkg::unit_mult;
  assign mult_sel = mult_wr && word[ctrl_pkg::sel_bit]; // sel stays low unless this unit is written
  assign mult_oe = unit_oe && src == ctrl_pkg::unit_mult;
  assign accum_wr = unit_wr && dst == ctrl_pkg::unit_accum;
  assign accum_sel = accum_wr && word[ctrl_pkg::sel_bit];
  assign accum_oe = unit_oe && src == ctrl_pkg::unit_accum;

  assign bus_data = imm_drive ? word[ctrl_pkg::imm_msb:ctrl_pkg::imm_lsb] : bus_pkg::data_idle;
  assign bus_attr = (imm_drive && word[ctrl_pkg::imm_inv_bit]) ? bus_pkg::attr_invalid
                                                               : bus_pkg::attr_idle;

  // done lasts one cycle, after which the program may be reloaded
  always_comb begin
    state_next = state;
    case (state)
      ctrl_pkg::st_idle: if (start) state_next = ctrl_pkg::st_run;
      ctrl_pkg::st_run:  if (halt_word) state_next = ctrl_pkg::st_done;
      ctrl_pkg::st_done: state_next = start ? ctrl_pkg::st_run : ctrl_pkg::st_idle;
      default:           state_next = ctrl_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ctrl_pkg::st_idle;
      pc <= '0;
      result_valid <= 1'b0;
    end else begin
      state <= state_next;
      if (!run) begin
        pc <= '0; // every start begins at the first word
      end else begin
        pc <= pc + 1'b1;
      end
      result_valid <= out_word;
    end
  end

  always_ff @(posedge clk) begin
    if (out_word) begin
      result_data <= bus_in_data;
      result_attr <= bus_in_attr;
    end
  end

  assign busy = run;
  assign done = state == ctrl_pkg::st_done;

  // the bus is a plain OR, so a unit driving out of turn corrupts the immediate or the idle bus
  a_one_driver: assert property (
    @(posedge clk) disable iff (rst)
    !(mult_oe || accum_oe) |-> bus_in_data == bus_data && bus_in_attr == bus_attr
  );

  a_prog_wr_idle: assert property (
    @(posedge clk) disable iff (rst) prog_wr |-> state == ctrl_pkg::st_idle
  );

endmodule

// ==== verilog/pu_fabric_top.sv ====
`timescale 1ns/1ns

module pu_fabric_top (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  start,

  input  logic                                  prog_wr,
  input  logic [ctrl_pkg::prog_addr_width-1:0]  prog_addr,
  input  logic [ctrl_pkg::prog_word_width-1:0]  prog_data,

  output logic [bus_pkg::data_width-1:0]        result_data,
  output logic [bus_pkg::attr_bus_width-1:0]    result_attr,
  output logic                                  result_valid,
  output logic                                  busy,
  output logic                                  done
);

  logic [bus_pkg::data_width-1:0]     bus_data;
  logic [bus_pkg::attr_bus_width-1:0] bus_attr;

  logic [bus_pkg::data_width-1:0]     mult_data;
  logic [bus_pkg::attr_bus_width-1:0] mult_attr;
  logic [bus_pkg::data_width-1:0]     accum_data;
  logic [bus_pkg::attr_bus_width-1:0] accum_attr;
  logic [bus_pkg::data_width-1:0]     seq_data;
  logic [bus_pkg::attr_bus_width-1:0] seq_attr;

  logic mult_wr;
  logic mult_sel;
  logic mult_oe;
  logic accum_wr;
  logic accum_sel;
  logic accum_oe;

  // every driver is zero when idle
  assign bus_data = mult_data | accum_data | seq_data;
  assign bus_attr = mult_attr | accum_attr | seq_attr;

  pu_mult i_pu_mult (
    .clk        (clk),
    .rst        (rst),
    .signal_wr  (mult_wr),
    .signal_sel (mult_sel),
    .data_in    (bus_data),
    .attr_in    (bus_attr),
    .signal_oe  (mult_oe),
    .data_out   (mult_data),
    .attr_out   (mult_attr)
  );

  pu_accum i_pu_accum (
    .clk        (clk),
    .rst        (rst),
    .signal_wr  (accum_wr),
    .signal_sel (accum_sel),
    .data_in    (bus_data),
    .attr_in    (bus_attr),
    .signal_oe  (accum_oe),
    .data_out   (accum_data),
    .attr_out   (accum_attr)
  );

  microcode_seq i_microcode_seq (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .prog_wr      (prog_wr),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .bus_in_data  (bus_data),
    .bus_in_attr  (bus_attr),
    .mult_wr      (mult_wr),
    .mult_sel     (mult_sel),
    .mult_oe      (mult_oe),
    .accum_wr     (accum_wr),
    .accum_sel    (accum_sel),
    .accum_oe     (accum_oe),
    .bus_data     (seq_data),
    .bus_attr     (seq_attr),
    .result_data  (result_data),
    .result_attr  (result_attr),
    .result_valid (result_valid),
    .busy         (busy),
    .done         (done)
  );

endmodule

// ==== verification/tb_pu_fabric.sv ====
`timescale 1ns/1ns

module tb_pu_fabric;

  localparam int dw = bus_pkg::data_width;
  localparam int aw = bus_pkg::attr_bus_width;
  localparam int hw = bus_pkg::half_width;
  localparam int ww = ctrl_pkg::prog_word_width;
  localparam int clk_period = 20;
  localparam int reset_cycles = 8;
  localparam int mult_tests = 4;
  localparam int prog_a_len = 5 * mult_tests + 1;
  localparam int prog_b_len = 18;
  localparam int run_overhead = 6; // load tail, start pulse and done cycle
  localparam int watchdog_cycles = reset_cycles + 2 * (2 * prog_a_len + run_overhead)
                                 + 2 * prog_b_len + run_overhead + 100;

  logic                                 clk;
  logic                                 rst;
  logic                                 start;
  logic                                 prog_wr;
  logic [ctrl_pkg::prog_addr_width-1:0] prog_addr;
  logic [ww-1:0]                        prog_data;
  logic [dw-1:0]                        result_data;
  logic [aw-1:0]                        result_attr;
  logic                                 result_valid;
  logic                                 busy;
  logic                                 done;

  logic [31:0]      lfsr;
  logic [ww-1:0]    prog_q [$];
  logic [aw+dw-1:0] exp_q [$]; // {attr, data} in the order of the op_out words
  int               exp_cyc_q [$]; // run cycle in which each result should be valid
  logic [aw+dw-1:0] exp_head;
  int               exp_cyc_head;
  logic             exp_avail;
  logic             valid_seen;
  logic             started;
  int               run_cycle;
  int               err_count;
  int               result_count;
  int               ref_acc;
  logic             ref_inv;

  pu_fabric_top i_pu_fabric_top (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .prog_wr      (prog_wr),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .result_data  (result_data),
    .result_attr  (result_attr),
    .result_valid (result_valid),
    .busy         (busy),
    .done         (done)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [dw-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[dw-2:0], lfsr[0]}; // one step for every bit
    end
  endtask

  task automatic rand_half(output logic [dw-1:0] v);
    logic [dw-1:0] r;
    take_bits(hw, r);
    v = {{(dw-hw){r[hw-1]}}, r[hw-1:0]};
  endtask

  task automatic rand_small(output logic [dw-1:0] v);
    logic [dw-1:0] r;
    take_bits(24, r);
    v = {{(dw-24){r[23]}}, r[23:0]};
  endtask

  // a value fits when it equals the sign extension of its low half
  function automatic logic fits_operand(input logic [dw-1:0] v);
    return v == {{(dw-hw){v[hw-1]}}, v[hw-1:0]};
  endfunction

  function automatic logic [dw-1:0] mult_ref(input logic [dw-1:0] a, input logic [dw-1:0] b);
    int pa;
    int pb;
    pa = int'(shortint'(a[hw-1:0]));
    pb = int'(shortint'(b[hw-1:0]));
    return pa * pb;
  endfunction

  task automatic model_load(input logic [dw-1:0] v, input logic inv);
    ref_acc = v;
    ref_inv = inv;
  endtask

  task automatic model_add(input logic [dw-1:0] v, input logic inv);
    longint s;
    s = longint'(ref_acc) + longint'($signed(v));
    ref_inv = ref_inv | inv | (s > 64'sd2147483647) | (s < -64'sd2147483648);
    ref_acc = int'(s);
  endtask

  // word k runs in cycle k + 1 of the program and its result is valid one cycle later
  task automatic expect_result(input logic [dw-1:0] data, input logic inv);
    logic [aw-1:0] attr;
    attr = '0;
    attr[bus_pkg::invalid_bit] = inv;
    exp_q.push_back({attr, data});
    exp_cyc_q.push_back(prog_q.size() + 1);
  endtask

  function automatic logic [ww-1:0] make_word(input ctrl_pkg::opcode_t op, input logic halt,
      input ctrl_pkg::unit_id_t src, input ctrl_pkg::unit_id_t dst, input logic sel,
      input logic inv, input logic [dw-1:0] imm);
    logic [ww-1:0] w;
    w = '0;
    w[ctrl_pkg::opcode_msb:ctrl_pkg::opcode_lsb] = op;
    w[ctrl_pkg::halt_bit] = halt;
    w[ctrl_pkg::src_bit] = src;
    w[ctrl_pkg::dst_bit] = dst;
    w[ctrl_pkg::sel_bit] = sel;
    w[ctrl_pkg::imm_inv_bit] = inv;
    w[ctrl_pkg::imm_msb:ctrl_pkg::imm_lsb] = imm;
    return w;
  endfunction

  task automatic imm_to(input ctrl_pkg::unit_id_t dst, input logic sel, input logic inv,
      input logic [dw-1:0] imm);
    prog_q.push_back(make_word(ctrl_pkg::op_imm, 1'b0, ctrl_pkg::unit_mult, dst, sel, inv, imm));
  endtask

  task automatic send_unit(input ctrl_pkg::unit_id_t src, input ctrl_pkg::unit_id_t dst,
      input logic sel);
    prog_q.push_back(make_word(ctrl_pkg::op_send, 1'b0, src, dst, sel, 1'b0, '0));
  endtask

  task automatic read_unit(input ctrl_pkg::unit_id_t src);
    prog_q.push_back(make_word(ctrl_pkg::op_out, 1'b0, src, ctrl_pkg::unit_mult, 1'b0, 1'b0, '0));
  endtask

  task automatic pad_nop(input bit halt);
    prog_q.push_back(make_word(ctrl_pkg::op_nop, halt, ctrl_pkg::unit_mult, ctrl_pkg::unit_mult,
                               1'b0, 1'b0, '0));
  endtask

  // two nops let the product settle before it is read
  task automatic mult_case(input logic [dw-1:0] a, input logic inv_a, input logic [dw-1:0] b,
      input logic inv_b);
    imm_to(ctrl_pkg::unit_mult, 1'b0, inv_a, a);
    imm_to(ctrl_pkg::unit_mult, 1'b1, inv_b, b);
    pad_nop(1'b0);
    pad_nop(1'b0);
    read_unit(ctrl_pkg::unit_mult);
    expect_result(mult_ref(a, b), !fits_operand(a) || !fits_operand(b) || inv_a || inv_b);
  endtask

  task automatic build_mult_prog();
    logic [dw-1:0] a;
    logic [dw-1:0] b;
    prog_q.delete();
    for (int t = 0; t < mult_tests; t++) begin
      rand_half(a);
      rand_half(b);
      if (t == 2) begin
        take_bits(dw, a);
        a[dw-1] = 1'b0;
        a[hw] = 1'b1; // upper bits can no longer be uniform
      end
      mult_case(a, 1'b0, b, t == 3);
    end
    pad_nop(1'b1);
  endtask

  task automatic build_accum_prog();
    logic [dw-1:0] x;
    logic [dw-1:0] a;
    logic [dw-1:0] b;
    prog_q.delete();
    rand_small(x);
    imm_to(ctrl_pkg::unit_accum, 1'b0, 1'b0, x);
    model_load(x, 1'b0);
    repeat (2) begin
      rand_small(x);
      imm_to(ctrl_pkg::unit_accum, 1'b1, 1'b0, x);
      model_add(x, 1'b0);
    end
    read_unit(ctrl_pkg::unit_accum);
    expect_result(ref_acc, ref_inv);
    rand_half(a);
    rand_half(b);
    imm_to(ctrl_pkg::unit_mult, 1'b0, 1'b0, a);
    imm_to(ctrl_pkg::unit_mult, 1'b1, 1'b0, b);
    pad_nop(1'b0);
    pad_nop(1'b0);
    send_unit(ctrl_pkg::unit_mult, ctrl_pkg::unit_accum, 1'b1);
    model_add(mult_ref(a, b), 1'b0);
    read_unit(ctrl_pkg::unit_accum);
    expect_result(ref_acc, ref_inv);
    take_bits(hw, x);
    x = x | 32'h7000_0000;
    imm_to(ctrl_pkg::unit_accum, 1'b0, 1'b0, x);
    model_load(x, 1'b0);
    take_bits(hw, x);
    x = x | 32'h4000_0000; // sum passes the positive limit
    imm_to(ctrl_pkg::unit_accum, 1'b1, 1'b0, x);
    model_add(x, 1'b0);
    read_unit(ctrl_pkg::unit_accum);
    expect_result(ref_acc, ref_inv);
    rand_half(x);
    imm_to(ctrl_pkg::unit_accum, 1'b1, 1'b0, x);
    model_add(x, 1'b0);
    read_unit(ctrl_pkg::unit_accum);
    expect_result(ref_acc, ref_inv);
    rand_small(x);
    imm_to(ctrl_pkg::unit_accum, 1'b0, 1'b0, x);
    model_load(x, 1'b0);
    read_unit(ctrl_pkg::unit_accum);
    expect_result(ref_acc, ref_inv);
    pad_nop(1'b1);
  endtask

  task automatic load_program();
    for (int i = 0; i < prog_q.size(); i++) begin
      @(posedge clk);
      prog_wr <= 1'b1;
      prog_addr <= i[ctrl_pkg::prog_addr_width-1:0];
      prog_data <= prog_q[i];
    end
    @(posedge clk);
    prog_wr <= 1'b0;
  endtask

  // the halt word is the last one, so done shows up len + 1 cycles after start
  task automatic run_program(input int len);
    int   cycles;
    logic seen;
    @(posedge clk);
    start <= 1'b1;
    started <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    cycles = 1;
    seen = 1'b0;
    while (!seen && cycles <= len + run_overhead) begin
      @(negedge clk);
      if (done) begin
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!seen) begin
      err_count++;
      $display("done did not arrive within %0d cycles at %0t", len + run_overhead, $time);
    end else begin
      a_done_cycle: assert (cycles == len + 1) else begin
        err_count++;
        $display("Fail %0t done cycle got %0d expected %0d", $time, cycles, len + 1);
      end
    end
  endtask

  always @(negedge clk) begin
    valid_seen = !rst && result_valid;
    if (valid_seen) result_count++;
  end

  always @(posedge clk) begin
    if (valid_seen && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      void'(exp_cyc_q.pop_front());
    end
    exp_avail = exp_q.size() > 0;
    exp_head = exp_avail ? exp_q[0] : '0;
    exp_cyc_head = exp_avail ? exp_cyc_q[0] : 0;
    run_cycle = start ? 1 : run_cycle + 1; // counts the same way as run_program
  end

  a_quiet_before_start: assert property (@(negedge clk) disable iff (rst)
    !started |-> !busy && !done && !result_valid)
    else begin
      err_count++;
      $display("busy, done or result_valid went high before the first start at %0t", $time);
    end

  a_reset_clears: assert property (@(negedge clk) $past(rst) |-> !busy && !done && !result_valid)
    else begin
      err_count++;
      $display("outputs were not cleared by reset at %0t", $time);
    end

  a_done_pulse: assert property (@(negedge clk) disable iff (rst) done |=> !done)
    else begin
      err_count++;
      $display("done stayed high for more than one cycle at %0t", $time);
    end

  a_done_ends_busy: assert property (@(negedge clk) disable iff (rst)
    $rose(done) |-> $past(busy) && !busy)
    else begin
      err_count++;
      $display("done rose without busy falling at %0t", $time);
    end

  a_busy_falls_on_done: assert property (@(negedge clk) disable iff (rst) $fell(busy) |-> done)
    else begin
      err_count++;
      $display("busy fell without a done pulse at %0t", $time);
    end

  a_result_expected: assert property (@(negedge clk) disable iff (rst) result_valid |-> exp_avail)
    else begin
      err_count++;
      $display("result_valid pulsed at %0t with no result expected", $time);
    end

  a_result_cycle: assert property (@(negedge clk) disable iff (rst)
    result_valid && exp_avail |-> run_cycle == exp_cyc_head)
    else begin
      err_count++;
      $display("Fail %0t result_valid cycle got %0d expected %0d", $time, run_cycle,
               exp_cyc_head);
    end

  a_result_data: assert property (@(negedge clk) disable iff (rst)
    result_valid && exp_avail |-> result_data == exp_head[dw-1:0])
    else begin
      err_count++;
      $display("Fail %0t result_data got %h expected %h", $time, result_data, exp_head[dw-1:0]);
    end

  a_result_attr: assert property (@(negedge clk) disable iff (rst)
    result_valid && exp_avail |-> result_attr == exp_head[aw+dw-1:dw])
    else begin
      err_count++;
      $display("Fail %0t result_attr got %h expected %h", $time, result_attr,
               exp_head[aw+dw-1:dw]);
    end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired after %0d cycles", watchdog_cycles);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    start = 1'b0;
    prog_wr = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    started = 1'b0;
    valid_seen = 1'b0;
    exp_avail = 1'b0;
    exp_head = '0;
    exp_cyc_head = 0;
    run_cycle = 0;
    err_count = 0;
    result_count = 0;
    ref_acc = 0;
    ref_inv = 1'b0;
    lfsr = 32'h6a9e57af;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    build_mult_prog();
    load_program();
    run_program(prog_q.size());
    build_accum_prog();
    load_program();
    run_program(prog_q.size());
    build_mult_prog(); // same program shape, fresh immediates
    load_program();
    run_program(prog_q.size());
    @(posedge clk);
    a_all_results: assert (exp_q.size() == 0) else begin
      err_count++;
      $display("%0d expected results never appeared", exp_q.size());
    end
    $display("results checked %0d, errors %0d", result_count, err_count);
    if (err_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
verilog/bus_pkg.sv
verilog/ctrl_pkg.sv
verilog/pu_mult.sv
verilog/pu_accum.sv
verilog/microcode_seq.sv
verilog/pu_fabric_top.sv
verification/tb_pu_fabric.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_pu_fabric
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
